// File: src/quplsPkg.sv
// ============================
// Qupls decode front package
// Instruction layout, opcode and branch-kind encodings
// and the width of the in-order sequence tag
// ============================

package quplsPkg;

	// ============================
	// Instruction word layout
	// ============================

	// Raw instruction word as it leaves fetch
	localparam int InstrWidth = 32;

	// Register specifiers address a 64-entry architectural file
	localparam int RegWidth = 6;

	// Primary opcode occupies the low bits of the word
	localparam int OpcodeWidth = 7;

	// Low bit of each field, the upper bit follows from the field width
	localparam int OpcodeLsb = 0;
	localparam int RtLsb = 7;
	localparam int RaLsb = 13;
	localparam int RbLsb = 19;

	// Sequence tag wraps around, downstream compares it modulo 2**TagWidth
	localparam int TagWidth = 8;

	// Branch-kind encoding width
	localparam int BrKindWidth = 3;

	// ============================
	// Opcodes
	// ============================

	// Encodings are fixed; values not listed decode as an unknown
	// instruction that is neither flow control nor a register writer
	typedef enum logic [OpcodeWidth-1:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd4,
		OP_ADDI  = 7'd5,
		OP_CHK   = 7'd24,
		OP_JSR   = 7'd32,
		OP_JSRI  = 7'd33,
		OP_BSR   = 7'd34,
		OP_RTD   = 7'd35,
		OP_DBRA  = 7'd40,
		OP_Bcc   = 7'd41,
		OP_BccU  = 7'd42,
		OP_FBcc  = 7'd43,
		OP_LOAD  = 7'd64,
		OP_STORE = 7'd72
	} opcodeE;

	// How the branch unit treats a flow-control instruction
	// BK_NONE marks anything that does not redirect the stream
	typedef enum logic [BrKindWidth-1:0] {
		BK_NONE = 3'd0,
		BK_COND = 3'd1,
		BK_CALL = 3'd2,
		BK_RET  = 3'd3,
		BK_CHK  = 3'd4
	} branchKindE;

endpackage

// File: src/quplsInstrQueue.sv
// ============================
// Qupls instruction queue
// Circular buffer of raw instruction words with a
// registered head; each accepted word gets a sequence tag
// ============================

`timescale 1ns/1ps

module quplsInstrQueue #(
	parameter int QueueDepth = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            inValid,
	input  logic [quplsPkg::InstrWidth-1:0] instr,
	output logic                            inReady,
	output logic                            qValid,
	output logic [quplsPkg::InstrWidth-1:0] qInstr,
	output logic [quplsPkg::TagWidth-1:0]   qTag,
	input  logic                            qReady
);
	import quplsPkg::*;

	// A depth of one still needs a one-bit pointer
	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CntWidth = $clog2(QueueDepth + 1);
	localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(QueueDepth - 1);
	localparam logic [CntWidth-1:0] FullCnt = CntWidth'(QueueDepth);

	// Word storage and the tag stamped on each word at entry
	logic [InstrWidth-1:0] instrMem [QueueDepth];
	logic [TagWidth-1:0]   tagMem [QueueDepth];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;
	logic [TagWidth-1:0] nextTag;
	logic                push;
	logic                pop;

	// Accept while the buffer has a free slot
	assign inReady = (count != FullCnt);
	assign push = inValid && inReady;

	// Move the oldest word into the head register when the head
	// is empty or is handed to decode on this edge
	// An empty buffer never bypasses, so a new word reaches the head
	// one edge after it was written
	assign pop = (count != '0) && (!qValid || qReady);

	// ============================
	// Control state
	// ============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			nextTag <= '0;
			qValid <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
				// Tag counter simply wraps
				nextTag <= nextTag + 1'b1;
			end
			if (pop)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
			// Occupancy of the buffer, the head register is not counted
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Head valid follows the refill decision whenever the head can change
			if (!qValid || qReady)
				qValid <= pop;
		end
	end

	// ============================
	// Storage and head payload
	// ============================

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			instrMem[wrPtr] <= instr;
			tagMem[wrPtr] <= nextTag;
		end
		// Head payload only changes together with a refill
		if (pop)
		begin
			qInstr <= instrMem[rdPtr];
			qTag <= tagMem[rdPtr];
		end
	end

endmodule

// File: src/quplsDecodeFc.sv
// ============================
// Qupls flow-control classifier
// Flags checks, calls, branches and returns and
// says whether the opcode writes its Rt register
// ============================

`timescale 1ns/1ps

module quplsDecodeFc (
	input  quplsPkg::opcodeE     opcode,
	output logic                 fc,
	output quplsPkg::branchKindE brKind,
	output logic                 writesRt
);
	import quplsPkg::*;

	// Branch kind per opcode, anything unlisted is plain sequential code
	always_comb
	begin
		brKind = BK_NONE;
		case (opcode)
			OP_CHK:
				brKind = BK_CHK;
			OP_JSR, OP_JSRI, OP_BSR:
				brKind = BK_CALL;
			OP_DBRA, OP_Bcc, OP_BccU, OP_FBcc:
				brKind = BK_COND;
			OP_RTD:
				brKind = BK_RET;
			default:
				brKind = BK_NONE;
		endcase
	end

	// Every redirecting kind counts as flow control
	assign fc = (brKind != BK_NONE);

	// Calls write the link register and DBRA writes back its counter
	always_comb
	begin
		case (opcode)
			OP_ADD, OP_ADDI, OP_LOAD:
				writesRt = 1'b1;
			OP_JSR, OP_JSRI, OP_BSR, OP_DBRA:
				writesRt = 1'b1;
			default:
				writesRt = 1'b0;
		endcase
	end

endmodule

// File: src/quplsDecodeStage.sv
// ============================
// Qupls decode stage
// Splits the queue head into opcode and register
// fields and classifies it, purely combinational
// ============================

`timescale 1ns/1ps

module quplsDecodeStage (
	// Queue head
	input  logic                            qValid,
	input  logic [quplsPkg::InstrWidth-1:0] qInstr,
	input  logic [quplsPkg::TagWidth-1:0]   qTag,
	output logic                            qReady,

	// Decoded item towards the output register
	output logic                            decValid,
	input  logic                            decReady,
	output quplsPkg::opcodeE                opcode,
	output logic [quplsPkg::RegWidth-1:0]   rt,
	output logic [quplsPkg::RegWidth-1:0]   ra,
	output logic [quplsPkg::RegWidth-1:0]   rb,
	output logic                            fc,
	output quplsPkg::branchKindE            brKind,
	output logic                            writesRt,
	output logic [quplsPkg::TagWidth-1:0]   decTag
);
	import quplsPkg::*;

	// ============================
	// Field positions
	// ============================

	// Upper bit of each field from its low bit and width
	localparam int OpcodeMsb = OpcodeLsb + OpcodeWidth - 1;
	localparam int RtMsb = RtLsb + RegWidth - 1;
	localparam int RaMsb = RaLsb + RegWidth - 1;
	localparam int RbMsb = RbLsb + RegWidth - 1;

	logic [OpcodeWidth-1:0] rawOpcode;

	// ============================
	// Handshake
	// ============================

	// No storage here, so valid and ready pass straight through
	// and the item moves in the same cycle as the output register takes it
	assign decValid = qValid;
	assign qReady = decReady;

	// ============================
	// Field extraction
	// ============================

	assign rawOpcode = qInstr[OpcodeMsb:OpcodeLsb];

	// Unlisted encodings keep their raw value and fall to the
	// default arms of the classifier
	assign opcode = opcodeE'(rawOpcode);

	// Register specifiers are sliced whatever the opcode, rename
	// uses writesRt to decide whether Rt matters
	assign rt = qInstr[RtMsb:RtLsb];
	assign ra = qInstr[RaMsb:RaLsb];
	assign rb = qInstr[RbMsb:RbLsb];

	// Tag rides along unchanged so ordering survives decode
	assign decTag = qTag;

	// ============================
	// Classification
	// ============================

	// Flow-control flag, branch kind and write flag from the opcode only
	quplsDecodeFc uFc (
		.opcode   (opcode),
		.fc       (fc),
		.brKind   (brKind),
		.writesRt (writesRt)
	);

endmodule

// File: src/quplsDecodeOut.sv
// ============================
// Qupls decode output register
// One-entry pipeline register that holds a decoded
// item for rename under back-pressure
// ============================

`timescale 1ns/1ps

module quplsDecodeOut (
	input  logic                          clk,
	input  logic                          rst,

	// Decoded item from the decode stage
	input  logic                          decValid,
	output logic                          decReady,
	input  quplsPkg::opcodeE              opcode,
	input  logic [quplsPkg::RegWidth-1:0] rt,
	input  logic [quplsPkg::RegWidth-1:0] ra,
	input  logic [quplsPkg::RegWidth-1:0] rb,
	input  logic                          fc,
	input  quplsPkg::branchKindE          brKind,
	input  logic                          writesRt,
	input  logic [quplsPkg::TagWidth-1:0] decTag,

	// Registered item towards rename
	output logic                          outValid,
	input  logic                          outReady,
	output quplsPkg::opcodeE              outOpcode,
	output logic [quplsPkg::RegWidth-1:0] outRt,
	output logic [quplsPkg::RegWidth-1:0] outRa,
	output logic [quplsPkg::RegWidth-1:0] outRb,
	output logic                          outFc,
	output quplsPkg::branchKindE          outBrKind,
	output logic                          outWritesRt,
	output logic [quplsPkg::TagWidth-1:0] outTag
);
	import quplsPkg::*;

	logic load;

	// Take a new item when empty or when the current one leaves this cycle
	// which keeps a full pipeline moving one item per clock
	assign decReady = !outValid || outReady;
	assign load = decValid && decReady;

	// Valid tracks the incoming valid whenever the slot can change
	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else if (decReady)
			outValid <= decValid;
	end

	// Payload holds still until the next load
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			outOpcode <= opcode;
			outRt <= rt;
			outRa <= ra;
			outRb <= rb;
			outFc <= fc;
			outBrKind <= brKind;
			outWritesRt <= writesRt;
			outTag <= decTag;
		end
	end

endmodule

// File: src/quplsDecodeTop.sv
// ============================
// Qupls decode front top level
// Instruction queue, decode stage and output register
// ============================

`timescale 1ns/1ps

module quplsDecodeTop #(
	parameter int QueueDepth = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            inValid,
	input  logic [quplsPkg::InstrWidth-1:0] instr,
	output logic                            inReady,
	output logic                            outValid,
	input  logic                            outReady,
	output quplsPkg::opcodeE                outOpcode,
	output logic [quplsPkg::RegWidth-1:0]   outRt,
	output logic [quplsPkg::RegWidth-1:0]   outRa,
	output logic [quplsPkg::RegWidth-1:0]   outRb,
	output logic                            outFc,
	output quplsPkg::branchKindE            outBrKind,
	output logic                            outWritesRt,
	output logic [quplsPkg::TagWidth-1:0]   outTag
);
	import quplsPkg::*;

	// Queue head
	logic                  qValid;
	logic                  qReady;
	logic [InstrWidth-1:0] qInstr;
	logic [TagWidth-1:0]   qTag;

	// Decoded item between decode and the output register
	logic                decValid;
	logic                decReady;
	opcodeE              opcode;
	logic [RegWidth-1:0] rt;
	logic [RegWidth-1:0] ra;
	logic [RegWidth-1:0] rb;
	logic                fc;
	branchKindE          brKind;
	logic                writesRt;
	logic [TagWidth-1:0] decTag;

	// Input side, one edge from accept to head
	quplsInstrQueue #(
		.QueueDepth (QueueDepth)
	) uQueue (
		.clk     (clk),
		.rst     (rst),
		.inValid (inValid),
		.instr   (instr),
		.inReady (inReady),
		.qValid  (qValid),
		.qInstr  (qInstr),
		.qTag    (qTag),
		.qReady  (qReady)
	);

	// Field split and classification in zero cycles
	quplsDecodeStage uDecode (
		.qValid   (qValid),
		.qInstr   (qInstr),
		.qTag     (qTag),
		.qReady   (qReady),
		.decValid (decValid),
		.decReady (decReady),
		.opcode   (opcode),
		.rt       (rt),
		.ra       (ra),
		.rb       (rb),
		.fc       (fc),
		.brKind   (brKind),
		.writesRt (writesRt),
		.decTag   (decTag)
	);

	// Output register, second edge of the two-cycle latency
	quplsDecodeOut uOut (
		.clk         (clk),
		.rst         (rst),
		.decValid    (decValid),
		.decReady    (decReady),
		.opcode      (opcode),
		.rt          (rt),
		.ra          (ra),
		.rb          (rb),
		.fc          (fc),
		.brKind      (brKind),
		.writesRt    (writesRt),
		.decTag      (decTag),
		.outValid    (outValid),
		.outReady    (outReady),
		.outOpcode   (outOpcode),
		.outRt       (outRt),
		.outRa       (outRa),
		.outRb       (outRb),
		.outFc       (outFc),
		.outBrKind   (outBrKind),
		.outWritesRt (outWritesRt),
		.outTag      (outTag)
	);

endmodule

// File: verif/quplsDecode_assertions.sv
// ============================
// Qupls decode front assertions
// Classification and back-pressure rules checked
// on the top-level ports, bound into the DUT
// ============================

`timescale 1ns/1ps

module quplsDecodeAssertions (
	input logic                          clk,
	input logic                          rst,
	input logic                          inReady,
	input logic                          outValid,
	input logic                          outReady,
	input quplsPkg::opcodeE              outOpcode,
	input logic [quplsPkg::RegWidth-1:0] outRt,
	input logic [quplsPkg::RegWidth-1:0] outRa,
	input logic [quplsPkg::RegWidth-1:0] outRb,
	input logic                          outFc,
	input quplsPkg::branchKindE          outBrKind,
	input logic                          outWritesRt,
	input logic [quplsPkg::TagWidth-1:0] outTag
);
	import quplsPkg::*;

	// Number of failed assertions, read by the testbench at the end
	int failCount = 0;

	logic       expFc;
	logic       expWritesRt;
	branchKindE expKind;

	// Flow control means checks, calls, conditional branches and returns
	assign expFc = outOpcode inside {OP_CHK, OP_JSR, OP_JSRI, OP_DBRA, OP_Bcc,
		OP_BccU, OP_FBcc, OP_BSR, OP_RTD};

	// Branch-kind table, the unused encoding lands on BK_NONE
	assign expKind = (outOpcode inside {OP_DBRA, OP_Bcc, OP_BccU, OP_FBcc}) ? BK_COND :
		(outOpcode inside {OP_JSR, OP_JSRI, OP_BSR}) ? BK_CALL :
		(outOpcode == OP_RTD) ? BK_RET :
		(outOpcode == OP_CHK) ? BK_CHK : BK_NONE;

	// Arithmetic, loads, calls (link) and DBRA (counter) write Rt
	assign expWritesRt = outOpcode inside {OP_ADD, OP_ADDI, OP_LOAD, OP_JSR, OP_JSRI,
		OP_BSR, OP_DBRA};

	// ============================

	fcRule: assert property (@(posedge clk) disable iff (rst) outValid |-> outFc == expFc)
	else
	begin
		failCount++;
		$error("Flow-control flag wrong for opcode %0d", outOpcode);
	end

	kindRule: assert property (@(posedge clk) disable iff (rst) outValid |-> outBrKind == expKind)
	else
	begin
		failCount++;
		$error("Branch kind %0d wrong for opcode %0d", outBrKind, outOpcode);
	end

	writeRule: assert property (@(posedge clk) disable iff (rst)
		outValid |-> outWritesRt == expWritesRt)
	else
	begin
		failCount++;
		$error("Register-write flag wrong for opcode %0d", outOpcode);
	end

	// A stalled item must not move or change
	holdRule: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outOpcode) && $stable(outRt)
		&& $stable(outRa) && $stable(outRb) && $stable(outFc) && $stable(outBrKind)
		&& $stable(outWritesRt) && $stable(outTag))
	else
	begin
		failCount++;
		$error("Output item changed while stalled");
	end

	// Reset leaves an empty pipeline that accepts input
	resetRule: assert property (@(posedge clk) rst |=> !outValid && inReady)
	else
	begin
		failCount++;
		$error("Pipeline not empty after reset");
	end

endmodule

bind quplsDecodeTop quplsDecodeAssertions uAsrt (.*);

// File: verif/quplsDecodeTb.sv
// ============================
// Qupls decode front testbench
// Seeded instruction stream with an in-order
// scoreboard and a back-pressure stall
// ============================

`timescale 1ns/1ps

module quplsDecodeTb;
	import quplsPkg::*;

	localparam int QueueDepth = 4;
	localparam int ClkPeriod = 40;
	localparam int WaitLimit = 200;

	// All fourteen opcodes plus one encoding that is not assigned
	localparam logic [OpcodeWidth-1:0] OpTable [15] = '{OP_NOP, OP_ADD, OP_ADDI, OP_LOAD,
		OP_STORE, OP_CHK, OP_JSR, OP_JSRI, OP_DBRA, OP_Bcc, OP_BccU, OP_FBcc, OP_BSR, OP_RTD,
		7'd100};

	logic                  clk;
	logic                  rst;
	logic                  inValid;
	logic [InstrWidth-1:0] instr;
	logic                  inReady;
	logic                  outValid;
	logic                  outReady;
	opcodeE                outOpcode;
	logic [RegWidth-1:0]   outRt;
	logic [RegWidth-1:0]   outRa;
	logic [RegWidth-1:0]   outRb;
	logic                  outFc;
	branchKindE            outBrKind;
	logic                  outWritesRt;
	logic [TagWidth-1:0]   outTag;

	// Words in flight with the oldest first and the tag the next item must carry
	logic [InstrWidth-1:0] sentWords [$];
	logic [TagWidth-1:0]   expTag;
	int valueErrors;
	int timeoutErrors;
	int totalErrors;
	int received;
	// Mode 0 keeps outReady high and mode 1 toggles it randomly
	// Mode 2 holds it low
	int readyMode;

	quplsDecodeTop #(.QueueDepth(QueueDepth)) dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			valueErrors++;
			$display("[FAIL] %0t: %s is %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	// Fields of the oldest sent word at the fixed instruction bit positions
	task automatic checkItem();
		logic [InstrWidth-1:0] word;
		if (sentWords.size() == 0)
		begin
			valueErrors++;
			$display("[FAIL] %0t: item with tag %0h left but nothing was sent", $time, outTag);
		end
		else
		begin
			word = sentWords.pop_front();
			compareField("opcode", outOpcode, word[6:0]);
			compareField("rt", outRt, word[12:7]);
			compareField("ra", outRa, word[18:13]);
			compareField("rb", outRb, word[24:19]);
			compareField("tag", outTag, expTag);
			expTag = expTag + 1'b1;
			received++;
		end
	endtask

	// Transfers are recorded on the edge where both sides agree
	always @(posedge clk)
	begin
		if (rst)
		begin
			sentWords.delete();
			expTag = '0;
		end
		else
		begin
			if (inValid && inReady)
				sentWords.push_back(instr);
			if (outValid && outReady)
				checkItem();
		end
	end

	// Advance one clock and move the inputs 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
		case (readyMode)
			0: outReady = 1'b1;
			1: outReady = 1'($urandom_range(1, 0));
			default: outReady = 1'b0;
		endcase
	endtask

	// Random register fields around the opcode at table position opIdx
	function automatic logic [InstrWidth-1:0] makeWord(input int opIdx);
		logic [InstrWidth-1:0] word;
		word = $urandom();
		word[6:0] = OpTable[opIdx];
		return word;
	endfunction

	task automatic sendWord(input logic [InstrWidth-1:0] word);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		inValid = 1'b1;
		instr = word;
		while (!taken && waited < WaitLimit)
		begin
			taken = inReady;
			step();
			waited++;
		end
		inValid = 1'b0;
		if (!taken)
		begin
			timeoutErrors++;
			$display("Timeout: the queue did not take a word within %0d cycles", WaitLimit);
		end
	endtask

	task automatic waitEmpty();
		int waited;
		waited = 0;
		while ((sentWords.size() != 0 || outValid) && waited < WaitLimit)
		begin
			step();
			waited++;
		end
		if (sentWords.size() != 0 || outValid)
		begin
			timeoutErrors++;
			$display("Timeout: %0d words never came out of the pipeline", sentWords.size());
		end
	endtask

	// Output register and queue head each hold one word on top of
	// the QueueDepth buffer entries before inReady drops
	task automatic runStall();
		int accepted;
		logic ready;
		logic fell;
		accepted = 0;
		fell = 1'b0;
		readyMode = 2;
		outReady = 1'b0;
		inValid = 1'b1;
		instr = makeWord($urandom_range(14, 0));
		for (int cyc = 0; cyc < 10; cyc++)
		begin
			ready = inReady;
			step();
			if (ready)
			begin
				accepted++;
				instr = makeWord($urandom_range(14, 0));
			end
			else if (!fell)
			begin
				fell = 1'b1;
				compareField("words taken before inReady fell", accepted, QueueDepth + 2);
			end
		end
		inValid = 1'b0;
		readyMode = 0;
		if (!fell)
		begin
			valueErrors++;
			$display("[FAIL] %0t: inReady stayed high through the stall", $time);
		end
	endtask

	initial
	begin
		void'($urandom(32'h929a));
		rst = 1'b1;
		inValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		readyMode = 0;
		valueErrors = 0;
		timeoutErrors = 0;
		received = 0;
		expTag = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		outReady = 1'b1;
		compareField("outValid after reset", outValid, 1'b0);
		compareField("inReady after reset", inReady, 1'b1);

		// Every table opcode once and back to back with a free output
		for (int i = 0; i < 15; i++)
			sendWord(makeWord(i));
		waitEmpty();

		// Random gaps on the input and random back-pressure
		readyMode = 1;
		for (int i = 0; i < 40; i++)
		begin
			sendWord(makeWord($urandom_range(14, 0)));
			repeat ($urandom_range(2, 0)) step();
		end
		readyMode = 0;
		waitEmpty();

		// Ten cycles with outReady low and then a drain of what piled up
		runStall();
		waitEmpty();

		totalErrors = valueErrors + timeoutErrors + dut.uAsrt.failCount;
		$display("Result: %0d items checked, %0d value errors, %0d timeouts, %0d assertion fails",
			received, valueErrors, timeoutErrors, dut.uAsrt.failCount);
		if (totalErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: quplsDecode.f
src/quplsPkg.sv
src/quplsInstrQueue.sv
src/quplsDecodeFc.sv
src/quplsDecodeStage.sv
src/quplsDecodeOut.sv
src/quplsDecodeTop.sv
verif/quplsDecode_assertions.sv
verif/quplsDecodeTb.sv

// File: Bender.yml
package:
  name: quplsDecode

sources:
  # Package first, then the blocks bottom up
  - src/quplsPkg.sv
  - src/quplsInstrQueue.sv
  - src/quplsDecodeFc.sv
  - src/quplsDecodeStage.sv
  - src/quplsDecodeOut.sv
  - src/quplsDecodeTop.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/quplsDecode_assertions.sv
      - verif/quplsDecodeTb.sv
